/* hw/dp_config.svh */
`ifndef DP_CONFIG_SVH
`define DP_CONFIG_SVH

// datapath word width
`define DP_WIDTH 32

// register file geometry
`define DP_NREGS 16
`define DP_RADDR_W 4

// program counter width
`define DP_PC_W 11

// register written on branch and link
`define DP_LR_IDX 14

`endif

/* hw/dp_pkg.sv */
`include "dp_config.svh"

package dp_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_RSB,  // b minus a
        ALU_AND,
        ALU_ORR,
        ALU_EOR,
        ALU_MOV,  // passes b
        ALU_MVN   // inverted b
    } alu_op_e;

    typedef enum logic [1:0] {
        SH_LSL,
        SH_LSR,
        SH_ASR,
        SH_ROR
    } shift_op_e;

    // forwarding source for the operand latches
    typedef enum logic [1:0] {
        FWD_RF,   // register file read
        FWD_ALU,  // alu result
        FWD_LDR,  // load data
        FWD_ALT   // pc, b operand or zero depending on the mux
    } fwd_sel_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        logic [`DP_RADDR_W-1:0] a_addr;
        logic [`DP_RADDR_W-1:0] b_addr;
        logic [`DP_RADDR_W-1:0] shift_addr;
        logic [`DP_RADDR_W-1:0] str_addr;
        logic [`DP_RADDR_W-1:0] w_addr1;
        logic                   w_en1;
        logic [1:0]             sel_w_addr1;  // 0 w_addr1, 1 lr, 2 a_addr
        logic [`DP_RADDR_W-1:0] w_addr_ldr;
        logic                   w_en_ldr;
        logic                   sel_load_lr;  // write lr_data instead of alu result
        logic [1:0]             sel_pc;       // 0 start, 1 increment, 2 alu target
        logic                   load_pc;
        fwd_sel_e               sel_a_in;
        fwd_sel_e               sel_b_in;
        fwd_sel_e               sel_shift_in;
        logic                   en_a;
        logic                   en_b;
        logic                   en_s;
        logic                   sel_shift;    // 1 register amount, 0 immediate
        shift_op_e              shift_op;
        logic                   sel_a_zero;
        logic                   sel_b_imm;
        logic                   sel_branch_imm;
        logic                   sel_pre_indexed;
        alu_op_e                alu_op;
        logic                   en_status;
    } dp_ctrl_t;

    typedef struct packed {
        logic [`DP_WIDTH-1:0] imm12;
        logic [`DP_WIDTH-1:0] imm_branch;
        logic [`DP_WIDTH-1:0] shift_imme;
        logic [`DP_PC_W-1:0]  start_pc;
        logic [`DP_WIDTH-1:0] ldr_data;
    } dp_imm_t;

endpackage

/* hw/regfile.sv */
`include "dp_config.svh"

module regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`DP_RADDR_W-1:0] a_addr,
    input  logic [`DP_RADDR_W-1:0] b_addr,
    input  logic [`DP_RADDR_W-1:0] shift_addr,
    input  logic [`DP_RADDR_W-1:0] str_addr,
    input  logic [`DP_RADDR_W-1:0] w_addr1,
    input  logic [`DP_WIDTH-1:0]   w_data1,
    input  logic                   w_en1,
    input  logic [`DP_RADDR_W-1:0] w_addr_ldr,
    input  logic [`DP_WIDTH-1:0]   w_data_ldr,
    input  logic                   w_en_ldr,
    input  logic [1:0]             sel_pc,
    input  logic                   load_pc,
    input  logic [`DP_PC_W-1:0]    start_pc,
    input  logic [`DP_PC_W-1:0]    dp_pc,
    output logic [`DP_WIDTH-1:0]   a_data,
    output logic [`DP_WIDTH-1:0]   b_data,
    output logic [`DP_WIDTH-1:0]   shift_data,
    output logic [`DP_WIDTH-1:0]   str_data,
    output logic [`DP_PC_W-1:0]    pc
);

    logic [`DP_WIDTH-1:0] regs [`DP_NREGS];
    logic [`DP_PC_W-1:0]  pc_q;
    logic [`DP_PC_W-1:0]  pc_next;

    // two write ports into the array
    always_ff @(posedge clk) begin
        if (w_en1) begin
            regs[w_addr1] <= w_data1;
        end
        // load port last so it wins a same-register collision
        if (w_en_ldr) begin
            regs[w_addr_ldr] <= w_data_ldr;
        end
    end

    // asynchronous reads
    assign a_data     = regs[a_addr];
    assign b_data     = regs[b_addr];
    assign shift_data = regs[shift_addr];
    assign str_data   = regs[str_addr];

    // next pc source
    always_comb begin
        case (sel_pc)
            2'd0:    pc_next = start_pc;
            2'd1:    pc_next = pc_q + 1'b1;
            2'd2:    pc_next = dp_pc;         // branch target from alu
            default: pc_next = pc_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else if (load_pc) begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

endmodule

/* hw/barrel_shifter.sv */
`include "dp_config.svh"

module barrel_shifter import dp_pkg::*; (
    input  logic [`DP_WIDTH-1:0] shift_in,
    input  shift_op_e            shift_op,
    input  logic [`DP_WIDTH-1:0] shift_amt,
    output logic [`DP_WIDTH-1:0] shift_out
);

    logic [4:0]             amt;      // only the low five bits count
    logic [2*`DP_WIDTH-1:0] doubled;
    logic [2*`DP_WIDTH-1:0] rotated;

    assign amt     = shift_amt[4:0];
    assign doubled = {shift_in, shift_in};
    assign rotated = doubled >> amt;  // low half is the rotate result

    always_comb begin
        if (amt == 5'd0) begin
            shift_out = shift_in;
        end else begin
            case (shift_op)
                SH_LSL:  shift_out = shift_in << amt;
                SH_LSR:  shift_out = shift_in >> amt;
                SH_ASR:  shift_out = $signed(shift_in) >>> amt;  // sign fill
                SH_ROR:  shift_out = rotated[`DP_WIDTH-1:0];
                default: shift_out = shift_in;
            endcase
        end
    end

endmodule

/* hw/alu.sv */
`include "dp_config.svh"

module alu import dp_pkg::*; (
    input  logic [`DP_WIDTH-1:0] val_a,
    input  logic [`DP_WIDTH-1:0] val_b,
    input  alu_op_e              alu_op,
    output logic [`DP_WIDTH-1:0] alu_out,
    output flags_t               flags
);

    localparam int MSB = `DP_WIDTH - 1;

    logic [`DP_WIDTH:0]   wide;   // result with carry out on top
    logic [`DP_WIDTH-1:0] res;
    logic                 carry;
    logic                 ovf;

    always_comb begin
        wide  = '0;
        res   = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (alu_op)
            ALU_ADD: begin
                wide  = {1'b0, val_a} + {1'b0, val_b};
                res   = wide[MSB:0];
                carry = wide[`DP_WIDTH];
                ovf   = (val_a[MSB] == val_b[MSB]) && (res[MSB] != val_a[MSB]);
            end
            ALU_SUB: begin
                // a + ~b + 1 so carry means no borrow
                wide  = {1'b0, val_a} + {1'b0, ~val_b} + 1'b1;
                res   = wide[MSB:0];
                carry = wide[`DP_WIDTH];
                ovf   = (val_a[MSB] != val_b[MSB]) && (res[MSB] != val_a[MSB]);
            end
            ALU_RSB: begin
                wide  = {1'b0, val_b} + {1'b0, ~val_a} + 1'b1;
                res   = wide[MSB:0];
                carry = wide[`DP_WIDTH];
                ovf   = (val_b[MSB] != val_a[MSB]) && (res[MSB] != val_b[MSB]);
            end
            ALU_AND: res = val_a & val_b;
            ALU_ORR: res = val_a | val_b;
            ALU_EOR: res = val_a ^ val_b;
            ALU_MOV: res = val_b;
            ALU_MVN: res = ~val_b;
            default: res = '0;
        endcase
    end

    assign alu_out = res;

    // n and z always track the result
    assign flags.n = res[MSB];
    assign flags.z = (res == '0);
    assign flags.c = carry;
    assign flags.v = ovf;

endmodule

/* hw/datapath.sv */
`include "dp_config.svh"

module datapath import dp_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  dp_ctrl_t             ctrl,
    input  dp_imm_t              imm,
    input  logic [`DP_WIDTH-1:0] lr_data,
    output logic [`DP_WIDTH-1:0] datapath_out,
    output flags_t               status_out,
    output logic [`DP_WIDTH-1:0] str_data,
    output logic [`DP_PC_W-1:0]  pc
);

    logic [`DP_RADDR_W-1:0] w_addr_res;
    logic [`DP_WIDTH-1:0]   w_data1;
    logic [`DP_WIDTH-1:0]   a_data, b_data, shift_data;
    logic [`DP_WIDTH-1:0]   alu_out;
    logic [`DP_WIDTH-1:0]   shift_out;
    logic [`DP_WIDTH-1:0]   val_a, val_b, imm_data;
    logic [`DP_WIDTH-1:0]   a_in, b_in, shift_in, shift_amt;
    logic [`DP_WIDTH-1:0]   pc_ext;
    flags_t                 flags;

    // operand latches, not reset
    logic [`DP_WIDTH-1:0]   a_q, b_q, s_q;
    flags_t                 status_q;

    // resolve write port 1 address
    always_comb begin
        case (ctrl.sel_w_addr1)
            2'd0:    w_addr_res = ctrl.w_addr1;
            2'd1:    w_addr_res = `DP_RADDR_W'(`DP_LR_IDX);  // link register
            2'd2:    w_addr_res = ctrl.a_addr;               // base writeback
            default: w_addr_res = ctrl.w_addr1;
        endcase
    end

    assign w_data1 = ctrl.sel_load_lr ? lr_data : alu_out;

    regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .a_addr     (ctrl.a_addr),
        .b_addr     (ctrl.b_addr),
        .shift_addr (ctrl.shift_addr),
        .str_addr   (ctrl.str_addr),
        .w_addr1    (w_addr_res),
        .w_data1    (w_data1),
        .w_en1      (ctrl.w_en1),
        .w_addr_ldr (ctrl.w_addr_ldr),
        .w_data_ldr (imm.ldr_data),
        .w_en_ldr   (ctrl.w_en_ldr),
        .sel_pc     (ctrl.sel_pc),
        .load_pc    (ctrl.load_pc),
        .start_pc   (imm.start_pc),
        .dp_pc      (alu_out[`DP_PC_W-1:0]),
        .a_data     (a_data),
        .b_data     (b_data),
        .shift_data (shift_data),
        .str_data   (str_data),
        .pc         (pc)
    );

    assign pc_ext = {{(`DP_WIDTH-`DP_PC_W){1'b0}}, pc};

    // forwarding muxes in front of the latches
    always_comb begin
        case (ctrl.sel_a_in)
            FWD_RF:  a_in = a_data;
            FWD_ALU: a_in = alu_out;
            FWD_LDR: a_in = imm.ldr_data;
            FWD_ALT: a_in = pc_ext;
            default: a_in = a_data;
        endcase
        case (ctrl.sel_b_in)
            FWD_RF:  b_in = b_data;
            FWD_ALU: b_in = alu_out;
            FWD_LDR: b_in = imm.ldr_data;
            FWD_ALT: b_in = val_b;   // recirculate current b operand
            default: b_in = b_data;
        endcase
        case (ctrl.sel_shift_in)
            FWD_RF:  shift_in = shift_data;
            FWD_ALU: shift_in = alu_out;
            FWD_LDR: shift_in = imm.ldr_data;
            FWD_ALT: shift_in = '0;
            default: shift_in = shift_data;
        endcase
    end

    assign shift_amt = ctrl.sel_shift ? shift_in : imm.shift_imme;

    always_ff @(posedge clk) begin
        if (ctrl.en_a) begin
            a_q <= a_in;
        end
        if (ctrl.en_b) begin
            b_q <= b_in;
        end
        if (ctrl.en_s) begin
            s_q <= shift_amt;
        end
    end

    barrel_shifter u_shifter (
        .shift_in  (b_q),
        .shift_op  (ctrl.shift_op),
        .shift_amt (s_q),
        .shift_out (shift_out)
    );

    assign imm_data = ctrl.sel_branch_imm ? imm.imm_branch : imm.imm12;
    assign val_a    = ctrl.sel_a_zero ? '0 : a_q;
    assign val_b    = ctrl.sel_b_imm ? imm_data : shift_out;

    alu u_alu (
        .val_a   (val_a),
        .val_b   (val_b),
        .alu_op  (ctrl.alu_op),
        .alu_out (alu_out),
        .flags   (flags)
    );

    // nzcv status register
    always_ff @(posedge clk) begin
        if (rst) begin
            status_q <= '0;
        end else if (ctrl.en_status) begin
            status_q <= flags;
        end
    end

    assign status_out   = status_q;
    assign datapath_out = ctrl.sel_pre_indexed ? val_a : alu_out;  // address before update

endmodule

/* sim/datapath_tb.sv */
`include "dp_config.svh"

module datapath_tb import dp_pkg::*; ();

    logic                 clk;
    logic                 rst;
    dp_ctrl_t             ctrl;
    dp_imm_t              imm;
    logic [`DP_WIDTH-1:0] lr_data;
    logic [`DP_WIDTH-1:0] datapath_out;
    logic [`DP_WIDTH-1:0] str_data;
    flags_t               status_out;
    logic [`DP_PC_W-1:0]  pc;

    logic [`DP_WIDTH-1:0] model_regs [`DP_NREGS];  // expected register contents
    integer               seed;
    int                   errors;
    int                   checks;

    datapath u_dut (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .imm          (imm),
        .lr_data      (lr_data),
        .datapath_out (datapath_out),
        .status_out   (status_out),
        .str_data     (str_data),
        .pc           (pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // shift one bit position at a time
    function automatic logic [31:0] model_shift(input logic [31:0] v, input shift_op_e op,
                                                input logic [31:0] amt);
        logic [31:0] r;
        int          i;
        r = v;
        for (i = 0; i < int'(amt[4:0]); i++) begin
            case (op)
                SH_LSL:  r = {r[30:0], 1'b0};
                SH_LSR:  r = {1'b0, r[31:1]};
                SH_ASR:  r = {r[31], r[31:1]};
                default: r = {r[0], r[31:1]};
            endcase
        end
        return r;
    endfunction

    // signed range check gives v, unsigned compare gives c
    function automatic void model_alu(input logic [31:0] a, input logic [31:0] b,
                                      input alu_op_e op, output logic [31:0] res,
                                      output flags_t fl);
        longint wide;
        fl = '0;
        case (op)
            ALU_ADD: begin
                wide = longint'($signed(a)) + longint'($signed(b));
                fl.c = ({1'b0, a} + {1'b0, b}) > 33'h0_ffff_ffff;
            end
            ALU_SUB: begin
                wide = longint'($signed(a)) - longint'($signed(b));
                fl.c = (a >= b);  // no borrow
            end
            default: wide = longint'($signed(b));  // mov
        endcase
        res  = wide[31:0];
        fl.n = res[31];
        fl.z = (res == 32'd0);
        fl.v = (op != ALU_MOV) && (wide > 64'sd2147483647 || wide < -64'sd2147483648);
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            errors++;
            $display("Mismatch in %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    // every cycle starts from an idle control word
    task automatic new_cycle();
        @(negedge clk);
        ctrl = '0;
    endtask

    task automatic load_reg(input int idx, input logic [31:0] v);
        new_cycle();
        ctrl.w_en_ldr   = 1'b1;
        ctrl.w_addr_ldr = idx;
        imm.ldr_data    = v;
        model_regs[idx] = v;
    endtask

    task automatic check_reg(input string name, input int idx);
        new_cycle();
        ctrl.str_addr = idx;
        #1;
        check_word(name, model_regs[idx], str_data);
    endtask

    // a and b from registers, shift amount from shift_imme
    task automatic latch_ops(input int a_idx, input int b_idx, input logic [31:0] amt);
        new_cycle();
        ctrl.a_addr     = a_idx;
        ctrl.b_addr     = b_idx;
        ctrl.en_a       = 1'b1;
        ctrl.en_b       = 1'b1;
        ctrl.en_s       = 1'b1;
        imm.shift_imme  = amt;
    endtask

    task automatic test_regs();
        logic [31:0] v;
        int          i;
        check_word("reset_pc", 32'd0, pc);
        check_word("reset_status", 32'd0, status_out);
        for (i = 0; i < `DP_NREGS; i++) begin
            v = $random(seed);
            load_reg(i, v);
        end
        for (i = 0; i < `DP_NREGS; i++) begin
            check_reg("reg_readback", i);
        end
        new_cycle();
        ctrl.w_en1       = 1'b1;
        ctrl.w_addr1     = 5;
        ctrl.sel_load_lr = 1'b1;
        lr_data          = $random(seed);
        ctrl.w_en_ldr    = 1'b1;
        ctrl.w_addr_ldr  = 5;
        v                = $random(seed);
        imm.ldr_data     = v;
        model_regs[5]    = v;  // load port wins
        check_reg("write_collision", 5);
    endtask

    task automatic test_shift_add();
        logic [31:0] amt;
        logic [31:0] res;
        flags_t      fl;
        int          k;
        for (k = 0; k < 4; k++) begin
            amt = ($random(seed) & 32'h1f) | 32'd1;  // never a pass-through amount
            latch_ops(1, 2, amt);
            new_cycle();
            ctrl.shift_op = shift_op_e'(k);
            ctrl.alu_op   = ALU_ADD;
            ctrl.w_en1    = 1'b1;
            ctrl.w_addr1  = 3;
            model_alu(model_regs[1], model_shift(model_regs[2], shift_op_e'(k), amt), ALU_ADD,
                      res, fl);
            #1;
            check_word("shift_add", res, datapath_out);
            model_regs[3] = res;
            check_reg("shift_add_writeback", 3);
        end
    endtask

    task automatic test_sub_flags();
        logic [31:0] minuend;
        logic [31:0] res;
        flags_t      fl;
        int          n;
        for (n = 0; n < 2; n++) begin
            minuend = $random(seed) & 32'hffff;
            load_reg(4, minuend);
            latch_ops(4, 0, 0);
            new_cycle();
            ctrl.alu_op    = ALU_SUB;
            ctrl.sel_b_imm = 1'b1;
            ctrl.en_status = 1'b1;
            imm.imm12      = (n == 0) ? minuend : minuend + 32'h100;  // equal, then larger
            model_alu(minuend, imm.imm12, ALU_SUB, res, fl);
            new_cycle();
            #1;
            check_word("sub_flags", fl, status_out);
        end
    endtask

    task automatic test_forwarding();
        logic [31:0] res1;
        logic [31:0] res2;
        flags_t      fl;
        latch_ops(1, 2, 0);
        new_cycle();
        ctrl.alu_op   = ALU_ADD;
        ctrl.en_a     = 1'b1;
        ctrl.sel_a_in = FWD_ALU;  // first result into a latch
        ctrl.en_b     = 1'b1;
        ctrl.b_addr   = 2;
        ctrl.en_s     = 1'b1;
        model_alu(model_regs[1], model_regs[2], ALU_ADD, res1, fl);
        #1;
        check_word("fwd_first", res1, datapath_out);
        new_cycle();
        ctrl.alu_op = ALU_ADD;
        model_alu(res1, model_regs[2], ALU_ADD, res2, fl);
        #1;
        check_word("fwd_chain", res2, datapath_out);
        new_cycle();
        ctrl.sel_a_zero = 1'b1;
        ctrl.alu_op     = ALU_MOV;
        #1;
        check_word("mov_zero_a", model_regs[2], datapath_out);
        new_cycle();
        ctrl.sel_a_zero = 1'b1;
        ctrl.alu_op     = ALU_ADD;  // zeroed a leaves only b
        #1;
        check_word("add_zero_a", model_regs[2], datapath_out);
        new_cycle();
        ctrl.sel_pre_indexed = 1'b1;
        #1;
        check_word("pre_indexed", res1, datapath_out);
    endtask

    task automatic test_shift_reg();
        logic [31:0] amt;
        int          n;
        load_reg(7, $random(seed) | 32'h8000_0000);  // negative so asr fills ones
        for (n = 0; n < 3; n++) begin
            amt = (n == 0) ? 32'd0 : (n == 1) ? 32'd4 : 32'd31;
            load_reg(6, amt);
            new_cycle();
            ctrl.b_addr     = 7;
            ctrl.shift_addr = 6;
            ctrl.en_b       = 1'b1;
            ctrl.en_s       = 1'b1;
            ctrl.sel_shift  = 1'b1;
            new_cycle();
            ctrl.sel_a_zero = 1'b1;
            ctrl.alu_op     = ALU_MOV;
            ctrl.shift_op   = SH_ASR;
            #1;
            check_word("asr_by_reg", model_shift(model_regs[7], SH_ASR, amt), datapath_out);
            new_cycle();
            ctrl.sel_a_zero = 1'b1;
            ctrl.alu_op     = ALU_MOV;
            ctrl.shift_op   = SH_ROR;
            #1;
            check_word("ror_by_reg", model_shift(model_regs[7], SH_ROR, amt), datapath_out);
        end
    endtask

    task automatic test_pc();
        logic [`DP_PC_W-1:0] exp_pc;
        logic [31:0]         res;
        logic [31:0]         v;
        flags_t              fl;
        exp_pc = $random(seed);
        new_cycle();
        ctrl.load_pc  = 1'b1;
        imm.start_pc  = exp_pc;
        new_cycle();
        ctrl.load_pc  = 1'b1;
        ctrl.sel_pc   = 2'd1;
        #1;
        check_word("pc_start", 32'(exp_pc), pc);
        exp_pc = exp_pc + 1'b1;
        new_cycle();
        ctrl.en_a     = 1'b1;
        ctrl.sel_a_in = FWD_ALT;  // pc into a latch
        #1;
        check_word("pc_increment", 32'(exp_pc), pc);
        new_cycle();
        ctrl.sel_b_imm      = 1'b1;
        ctrl.sel_branch_imm = 1'b1;
        ctrl.load_pc        = 1'b1;
        ctrl.sel_pc         = 2'd2;
        imm.imm_branch      = $random(seed);
        model_alu(32'(exp_pc), imm.imm_branch, ALU_ADD, res, fl);
        new_cycle();
        #1;
        check_word("pc_branch", 32'(res[`DP_PC_W-1:0]), pc);
        new_cycle();
        ctrl.w_en1       = 1'b1;
        ctrl.sel_w_addr1 = 2'd1;
        ctrl.sel_load_lr = 1'b1;
        v                = $random(seed);
        lr_data          = v;
        model_regs[`DP_LR_IDX] = v;
        check_reg("lr_write", `DP_LR_IDX);
    endtask

    initial begin
        seed    = 32'hac61;
        errors  = 0;
        checks  = 0;
        rst     = 1'b1;
        ctrl    = '0;
        imm     = '0;
        lr_data = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        test_regs();
        test_shift_add();
        test_sub_flags();
        test_forwarding();
        test_shift_reg();
        test_pc();
        @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+hw
hw/dp_pkg.sv
hw/regfile.sv
hw/barrel_shifter.sv
hw/alu.sv
hw/datapath.sv
sim/datapath_tb.sv

/* Bender.yml */
package:
  name: arm_datapath

sources:
  - include_dirs:
      - hw
    files:
      - hw/dp_pkg.sv
      - hw/regfile.sv
      - hw/barrel_shifter.sv
      - hw/alu.sv
      - hw/datapath.sv
      - target: test
        files:
          - sim/datapath_tb.sv
